/* rtl/silver_isa_pkg.sv */
// silver instruction set
// opcodes, alu and shift functions, and where each field sits in the word
`default_nettype none

package silver_isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [5:0]  reg_addr_t;

   typedef enum logic [5:0] {
      op_normal        = 6'd0,
      op_shift         = 6'd1,
      op_out           = 6'd6,
      op_in            = 6'd7,
      op_jump          = 6'd9,
      op_jump_zero     = 6'd10,
      op_jump_not_zero = 6'd11,
      op_load_const    = 6'd13,
      op_invalid       = 6'd15
   } opcode_e;

   typedef enum logic [3:0] {
      f_add, f_add_carry, f_sub, f_carry,
      f_overflow, f_inc, f_dec, f_mul,
      f_mul_hu, f_and, f_or, f_xor,
      f_equal, f_less, f_lower, f_snd
   } alu_func_e;

   typedef enum logic [1:0] {
      sh_sll, sh_srl, sh_sra, sh_ror
   } shift_func_e;

   localparam int w_msb = 30;
   localparam int w_lsb = 25;
   localparam int w_imm_bit = 31;
   localparam int a_msb = 22;
   localparam int a_lsb = 17;
   localparam int a_imm_bit = 23;
   localparam int b_msb = 15;
   localparam int b_lsb = 10;
   localparam int b_imm_bit = 16;
   localparam int func_msb = 9;
   localparam int func_lsb = 6;
   localparam int op_msb = 5;
   localparam int op_lsb = 0;
   localparam int lc_bit = 24;        // with bit 31 marks LoadConstant
   localparam int const_msb = 22;
   localparam int const_neg_bit = 23;

   localparam word_t invalid_instr = 32'h0000_003f;

endpackage

`default_nettype wire

/* rtl/silver_pipe_pkg.sv */
// silver pipeline types
// stage payloads and the forwarding and pc select codes
`default_nettype none

package silver_pipe_pkg;

   // decode to execute
   typedef struct packed {
      silver_isa_pkg::word_t     pc;
      silver_isa_pkg::opcode_e   opcode;
      silver_isa_pkg::alu_func_e func;
      silver_isa_pkg::reg_addr_t addr_a;
      silver_isa_pkg::reg_addr_t addr_b;
      silver_isa_pkg::reg_addr_t addr_w;
      logic                      imm_a;
      logic                      imm_b;
      logic                      imm_w;
      silver_isa_pkg::word_t     data_a;
      silver_isa_pkg::word_t     data_b;
      silver_isa_pkg::word_t     data_w;
      silver_isa_pkg::word_t     constant;
      logic                      valid;
   } decoded_t;

   // memory and writeback stages
   typedef struct packed {
      logic                      valid;
      logic                      wr_en;
      silver_isa_pkg::reg_addr_t addr;
      silver_isa_pkg::word_t     data;
      logic                      is_out;
   } retire_t;

   typedef enum logic [1:0] {keep, from_mem, from_wb} fwd_sel_e;

   typedef enum logic [1:0] {seq, taken} pc_sel_e;

endpackage

`default_nettype wire

/* rtl/silver_fetch.sv */
// silver fetch stage
// program counter and the fetch/decode register, flushed on a taken jump
`timescale 1ns/1ns
`default_nettype none

module silver_fetch #(
   parameter silver_isa_pkg::word_t reset_pc = '0
) (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   input  wire silver_isa_pkg::word_t    inst_rdata,
   input  wire silver_pipe_pkg::pc_sel_e pc_sel,
   input  wire silver_isa_pkg::word_t    jump_target,
   output silver_isa_pkg::word_t         pc,
   output silver_isa_pkg::word_t         fetched_instr,
   output silver_isa_pkg::word_t         fetched_pc
);

   always_ff @(posedge clk) begin
      if (!rst_n)
         pc <= reset_pc;
      else if (pc_sel == silver_pipe_pkg::taken)
         pc <= jump_target;
      else
         pc <= pc + 32'd4;
   end

   always_ff @(posedge clk) begin
      fetched_pc <= pc;
      if (!rst_n || pc_sel == silver_pipe_pkg::taken)
         fetched_instr <= silver_isa_pkg::invalid_instr;   // bubble
      else
         fetched_instr <= inst_rdata;
   end

endmodule

`default_nettype wire

/* rtl/silver_regfile.sv */
// silver register file
// 64 words, three read ports, write data bypassed to a matching read
`timescale 1ns/1ns
`default_nettype none

module silver_regfile (
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   input  wire silver_isa_pkg::reg_addr_t addr_a,
   input  wire silver_isa_pkg::reg_addr_t addr_b,
   input  wire silver_isa_pkg::reg_addr_t addr_w,
   output silver_isa_pkg::word_t          data_a,
   output silver_isa_pkg::word_t          data_b,
   output silver_isa_pkg::word_t          data_w,
   input  wire logic                      wr_en,
   input  wire silver_isa_pkg::reg_addr_t wr_addr,
   input  wire silver_isa_pkg::word_t     wr_data
);

   silver_isa_pkg::word_t regs [64];

   always_ff @(posedge clk) begin
      if (!rst_n)
         regs <= '{default: '0};
      else if (wr_en)
         regs[wr_addr] <= wr_data;
   end

   assign data_a = (wr_en && wr_addr == addr_a) ? wr_data : regs[addr_a];
   assign data_b = (wr_en && wr_addr == addr_b) ? wr_data : regs[addr_b];
   assign data_w = (wr_en && wr_addr == addr_w) ? wr_data : regs[addr_w];

endmodule

`default_nettype wire

/* rtl/silver_decode.sv */
// silver decode stage
// classifies the opcode, builds immediates and picks each operand
`timescale 1ns/1ns
`default_nettype none

module silver_decode (
   input  wire silver_isa_pkg::word_t instr,
   input  wire silver_isa_pkg::word_t instr_pc,
   output silver_isa_pkg::reg_addr_t  addr_a,
   output silver_isa_pkg::reg_addr_t  addr_b,
   output silver_isa_pkg::reg_addr_t  addr_w,
   input  wire silver_isa_pkg::word_t data_a,
   input  wire silver_isa_pkg::word_t data_b,
   input  wire silver_isa_pkg::word_t data_w,
   output silver_pipe_pkg::decoded_t  decoded
);

   silver_isa_pkg::opcode_e op;
   silver_isa_pkg::word_t   magnitude;

   function automatic silver_isa_pkg::word_t sext6(input logic [5:0] field);
      sext6 = {{26{field[5]}}, field};
   endfunction

   assign addr_a = instr[silver_isa_pkg::a_msb:silver_isa_pkg::a_lsb];
   assign addr_b = instr[silver_isa_pkg::b_msb:silver_isa_pkg::b_lsb];
   assign addr_w = instr[silver_isa_pkg::w_msb:silver_isa_pkg::w_lsb];
   assign magnitude = {9'd0, instr[silver_isa_pkg::const_msb:0]};

   always_comb begin
      op = silver_isa_pkg::op_invalid;
      if (instr[silver_isa_pkg::lc_bit]) begin
         if (instr[silver_isa_pkg::w_imm_bit])
            op = silver_isa_pkg::op_load_const;
      end else begin
         case (instr[silver_isa_pkg::op_msb:silver_isa_pkg::op_lsb])
            6'd10, 6'd11:
               op = silver_isa_pkg::opcode_e'(instr[5:0]);
            6'd0, 6'd1, 6'd6, 6'd7, 6'd9:
               if (!instr[silver_isa_pkg::w_imm_bit])
                  op = silver_isa_pkg::opcode_e'(instr[5:0]);
            default:
               op = silver_isa_pkg::op_invalid;
         endcase
      end
   end

   always_comb begin
      decoded.pc = instr_pc;
      decoded.opcode = op;
      if (op inside {silver_isa_pkg::op_normal, silver_isa_pkg::op_shift,
                     silver_isa_pkg::op_out, silver_isa_pkg::op_jump,
                     silver_isa_pkg::op_jump_zero, silver_isa_pkg::op_jump_not_zero})
         decoded.func = silver_isa_pkg::alu_func_e'(
            instr[silver_isa_pkg::func_msb:silver_isa_pkg::func_lsb]);
      else
         decoded.func = silver_isa_pkg::f_and;
      decoded.addr_a = addr_a;
      decoded.addr_b = addr_b;
      decoded.addr_w = addr_w;
      decoded.imm_a = instr[silver_isa_pkg::a_imm_bit];
      decoded.imm_b = instr[silver_isa_pkg::b_imm_bit];
      decoded.imm_w = instr[silver_isa_pkg::w_imm_bit];
      decoded.data_a = decoded.imm_a ? sext6(addr_a) : data_a;
      decoded.data_b = decoded.imm_b ? sext6(addr_b) : data_b;
      decoded.data_w = decoded.imm_w ? sext6(addr_w) : data_w;
      decoded.constant = instr[silver_isa_pkg::const_neg_bit] ? 32'd0 - magnitude : magnitude;
      decoded.valid = op != silver_isa_pkg::op_invalid;
   end

endmodule

`default_nettype wire

/* rtl/silver_forward.sv */
// silver forwarding select
// memory stage wins over writeback, immediates are never forwarded
`timescale 1ns/1ns
`default_nettype none

module silver_forward (
   input  wire silver_pipe_pkg::decoded_t ex,
   input  wire silver_pipe_pkg::retire_t  mem_stage,
   input  wire silver_pipe_pkg::retire_t  wb_stage,
   output silver_pipe_pkg::fwd_sel_e      fwd_a,
   output silver_pipe_pkg::fwd_sel_e      fwd_b,
   output silver_pipe_pkg::fwd_sel_e      fwd_w
);

   logic chk_a, chk_b, chk_w;

   function automatic silver_pipe_pkg::fwd_sel_e pick(
      input logic                      chk,
      input silver_isa_pkg::reg_addr_t addr,
      input silver_pipe_pkg::retire_t  mem_s,
      input silver_pipe_pkg::retire_t  wb_s
   );
      if (chk && mem_s.valid && mem_s.wr_en && mem_s.addr == addr)
         pick = silver_pipe_pkg::from_mem;
      else if (chk && wb_s.valid && wb_s.wr_en && wb_s.addr == addr)
         pick = silver_pipe_pkg::from_wb;
      else
         pick = silver_pipe_pkg::keep;
   endfunction

   assign chk_a = ex.valid && !ex.imm_a &&
                  !(ex.opcode inside {silver_isa_pkg::op_in, silver_isa_pkg::op_load_const});
   assign chk_b = ex.valid && !ex.imm_b &&
                  ex.opcode inside {silver_isa_pkg::op_normal, silver_isa_pkg::op_shift,
                                    silver_isa_pkg::op_out, silver_isa_pkg::op_jump_zero,
                                    silver_isa_pkg::op_jump_not_zero};
   assign chk_w = ex.valid && !ex.imm_w &&   // jump offset only
                  ex.opcode inside {silver_isa_pkg::op_jump_zero,
                                    silver_isa_pkg::op_jump_not_zero};

   assign fwd_a = pick(chk_a, ex.addr_a, mem_stage, wb_stage);
   assign fwd_b = pick(chk_b, ex.addr_b, mem_stage, wb_stage);
   assign fwd_w = pick(chk_w, ex.addr_w, mem_stage, wb_stage);

endmodule

`default_nettype wire

/* rtl/silver_execute.sv */
// silver execute stage
// alu with carry/overflow flags, shifter, result select and jump decision
`timescale 1ns/1ns
`default_nettype none

module silver_execute (
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   input  wire silver_pipe_pkg::decoded_t decoded,
   output silver_pipe_pkg::decoded_t      ex,
   output silver_pipe_pkg::pc_sel_e       pc_sel,
   output silver_isa_pkg::word_t          jump_target,
   input  wire logic [1:0]                data_in,
   input  wire silver_pipe_pkg::fwd_sel_e fwd_a,
   input  wire silver_pipe_pkg::fwd_sel_e fwd_b,
   input  wire silver_pipe_pkg::fwd_sel_e fwd_w,
   input  wire silver_pipe_pkg::retire_t  mem_stage,
   input  wire silver_pipe_pkg::retire_t  wb_stage,
   output silver_pipe_pkg::retire_t       result
);

   silver_isa_pkg::word_t a_val, b_val, w_val, alu_in1, alu_in2;
   silver_isa_pkg::word_t alu_res, shift_res, res_val, diff, pc_next;
   logic [32:0] sum;
   logic [63:0] prod;
   logic [4:0]  rot;
   logic        carry_q, overflow_q, carry_in, is_jump, uses_alu, writes_reg;

   function automatic silver_isa_pkg::word_t pick(
      input silver_pipe_pkg::fwd_sel_e sel,
      input silver_isa_pkg::word_t     own,
      input silver_isa_pkg::word_t     mem_val,
      input silver_isa_pkg::word_t     wb_val
   );
      case (sel)
         silver_pipe_pkg::from_mem: pick = mem_val;
         silver_pipe_pkg::from_wb:  pick = wb_val;
         default:                   pick = own;
      endcase
   endfunction

   always_ff @(posedge clk) begin
      ex <= decoded;
      if (!rst_n || pc_sel == silver_pipe_pkg::taken)
         ex.valid <= 1'b0;   // squashed
   end

   assign a_val = pick(fwd_a, ex.data_a, mem_stage.data, wb_stage.data);
   assign b_val = pick(fwd_b, ex.data_b, mem_stage.data, wb_stage.data);
   assign w_val = pick(fwd_w, ex.data_w, mem_stage.data, wb_stage.data);

   assign is_jump = ex.opcode == silver_isa_pkg::op_jump;
   assign alu_in1 = is_jump ? ex.pc : a_val;   // link jumps add pc and A
   assign alu_in2 = is_jump ? a_val : b_val;
   assign carry_in = (ex.func == silver_isa_pkg::f_add_carry) && carry_q;
   assign sum = {1'b0, alu_in1} + {1'b0, alu_in2} + {32'd0, carry_in};
   assign diff = alu_in1 - alu_in2;
   assign prod = {32'd0, alu_in1} * {32'd0, alu_in2};
   assign pc_next = ex.pc + 32'd4;

   always_comb begin
      case (ex.func)
         silver_isa_pkg::f_add, silver_isa_pkg::f_add_carry: alu_res = sum[31:0];
         silver_isa_pkg::f_sub:      alu_res = diff;
         silver_isa_pkg::f_carry:    alu_res = {31'd0, carry_q};
         silver_isa_pkg::f_overflow: alu_res = {31'd0, overflow_q};
         silver_isa_pkg::f_inc:      alu_res = alu_in1 + 32'd1;
         silver_isa_pkg::f_dec:      alu_res = alu_in1 - 32'd1;
         silver_isa_pkg::f_mul:      alu_res = prod[31:0];
         silver_isa_pkg::f_mul_hu:   alu_res = prod[63:32];
         silver_isa_pkg::f_and:      alu_res = alu_in1 & alu_in2;
         silver_isa_pkg::f_or:       alu_res = alu_in1 | alu_in2;
         silver_isa_pkg::f_xor:      alu_res = alu_in1 ^ alu_in2;
         silver_isa_pkg::f_equal:    alu_res = {31'd0, alu_in1 == alu_in2};
         silver_isa_pkg::f_less:     alu_res = {31'd0, $signed(alu_in1) < $signed(alu_in2)};
         silver_isa_pkg::f_lower:    alu_res = {31'd0, alu_in1 < alu_in2};
         default:                    alu_res = alu_in2;   // f_snd
      endcase
   end

   assign uses_alu = ex.opcode inside {silver_isa_pkg::op_normal, silver_isa_pkg::op_out,
                                       silver_isa_pkg::op_jump, silver_isa_pkg::op_jump_zero,
                                       silver_isa_pkg::op_jump_not_zero};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         carry_q <= 1'b0;
         overflow_q <= 1'b0;
      end else if (ex.valid && uses_alu) begin
         case (ex.func)
            silver_isa_pkg::f_add: begin
               carry_q <= sum[32];
               overflow_q <= (alu_in1[31] == alu_in2[31]) && (sum[31] != alu_in1[31]);
            end
            silver_isa_pkg::f_add_carry:
               carry_q <= sum[32];
            silver_isa_pkg::f_sub:
               overflow_q <= (alu_in1[31] != alu_in2[31]) && (diff[31] != alu_in1[31]);
            default: ;
         endcase
      end
   end

   assign rot = b_val[4:0];   // rotate amount mod 32

   always_comb begin
      case (silver_isa_pkg::shift_func_e'(ex.func[1:0]))
         silver_isa_pkg::sh_sll: shift_res = a_val << b_val;
         silver_isa_pkg::sh_srl: shift_res = a_val >> b_val;
         silver_isa_pkg::sh_sra: shift_res = $signed(a_val) >>> b_val;
         default:                shift_res = (a_val >> rot) | (a_val << (6'd32 - {1'b0, rot}));
      endcase
   end

   always_comb begin
      case (ex.opcode)
         silver_isa_pkg::op_shift:      res_val = shift_res;
         silver_isa_pkg::op_in:         res_val = {30'd0, data_in};
         silver_isa_pkg::op_jump:       res_val = pc_next;   // link
         silver_isa_pkg::op_load_const: res_val = ex.constant;
         default:                       res_val = alu_res;
      endcase
   end

   always_comb begin
      pc_sel = silver_pipe_pkg::seq;
      jump_target = ex.pc + w_val;
      if (ex.valid) begin
         case (ex.opcode)
            silver_isa_pkg::op_jump: begin
               pc_sel = silver_pipe_pkg::taken;
               jump_target = alu_res;
            end
            silver_isa_pkg::op_jump_zero:
               if (alu_res == '0)
                  pc_sel = silver_pipe_pkg::taken;
            silver_isa_pkg::op_jump_not_zero:
               if (alu_res != '0)
                  pc_sel = silver_pipe_pkg::taken;
            default: ;
         endcase
      end
   end

   assign writes_reg = ex.opcode inside {silver_isa_pkg::op_normal, silver_isa_pkg::op_shift,
                                         silver_isa_pkg::op_out, silver_isa_pkg::op_in,
                                         silver_isa_pkg::op_jump, silver_isa_pkg::op_load_const};

   assign result = '{valid:  ex.valid,
                     wr_en:  ex.valid && writes_reg,
                     addr:   ex.addr_w,
                     data:   res_val,
                     is_out: ex.opcode == silver_isa_pkg::op_out};

endmodule

`default_nettype wire

/* rtl/silver_retire.sv */
// silver memory and writeback stages
// carries results to the register file and drives the output port
`timescale 1ns/1ns
`default_nettype none

module silver_retire #(
   parameter int out_width = 10
) (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   input  wire silver_pipe_pkg::retire_t result,
   output silver_pipe_pkg::retire_t      mem_stage,
   output silver_pipe_pkg::retire_t      wb_stage,
   output logic                          wr_en,
   output silver_isa_pkg::reg_addr_t     wr_addr,
   output silver_isa_pkg::word_t         wr_data,
   output logic [out_width-1:0]          data_out,
   output logic                          out_strobe
);

   always_ff @(posedge clk) begin
      mem_stage <= result;
      wb_stage <= mem_stage;
      if (!rst_n) begin
         mem_stage.valid <= 1'b0;
         wb_stage.valid <= 1'b0;
      end
   end

   assign wr_en = wb_stage.valid && wb_stage.wr_en;
   assign wr_addr = wb_stage.addr;
   assign wr_data = wb_stage.data;

   // output port write pulse
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         data_out <= '0;
         out_strobe <= 1'b0;
      end else begin
         out_strobe <= wb_stage.valid && wb_stage.is_out;
         if (wb_stage.valid && wb_stage.is_out)
            data_out <= wb_stage.data[out_width-1:0];
      end
   end

endmodule

`default_nettype wire

/* rtl/silver_cpu.sv */
// silver five-stage pipelined core
// fetch, decode, execute, memory and writeback with operand forwarding
`timescale 1ns/1ns
`default_nettype none

module silver_cpu #(
   parameter silver_isa_pkg::word_t reset_pc = '0,
   parameter int out_width = 10
) (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire silver_isa_pkg::word_t inst_rdata,
   input  wire logic [1:0]            data_in,
   output silver_isa_pkg::word_t      pc,
   output logic [out_width-1:0]       data_out,
   output logic                       out_strobe
);

   silver_isa_pkg::word_t     fetched_instr, fetched_pc, jump_target;
   silver_isa_pkg::word_t     rf_a, rf_b, rf_w, wr_data;
   silver_isa_pkg::reg_addr_t addr_a, addr_b, addr_w, wr_addr;
   silver_pipe_pkg::pc_sel_e  pc_sel;
   silver_pipe_pkg::decoded_t decoded, ex;
   silver_pipe_pkg::fwd_sel_e fwd_a, fwd_b, fwd_w;
   silver_pipe_pkg::retire_t  result, mem_stage, wb_stage;
   logic                      wr_en;

   silver_fetch #(.reset_pc(reset_pc)) u_fetch (
      .clk, .rst_n, .inst_rdata, .pc_sel, .jump_target,
      .pc, .fetched_instr, .fetched_pc
   );

   silver_regfile u_regfile (
      .clk, .rst_n, .addr_a, .addr_b, .addr_w,
      .data_a(rf_a), .data_b(rf_b), .data_w(rf_w),
      .wr_en, .wr_addr, .wr_data
   );

   silver_decode u_decode (
      .instr(fetched_instr), .instr_pc(fetched_pc), .addr_a, .addr_b, .addr_w,
      .data_a(rf_a), .data_b(rf_b), .data_w(rf_w), .decoded
   );

   silver_forward u_forward (
      .ex, .mem_stage, .wb_stage, .fwd_a, .fwd_b, .fwd_w
   );

   silver_execute u_execute (
      .clk, .rst_n, .decoded, .ex, .pc_sel, .jump_target, .data_in,
      .fwd_a, .fwd_b, .fwd_w, .mem_stage, .wb_stage, .result
   );

   silver_retire #(.out_width(out_width)) u_retire (
      .clk, .rst_n, .result, .mem_stage, .wb_stage,
      .wr_en, .wr_addr, .wr_data, .data_out, .out_strobe
   );

endmodule

`default_nettype wire

/* testbench/silver_tb.sv */
// silver core testbench
// runs small programs from a ROM and checks the output port against a reference model
`timescale 1ns/1ns
`default_nettype none

module silver_tb;

   logic        clk = 1'b0;
   logic        rst_n;
   logic [31:0] inst_rdata;
   logic [1:0]  data_in;
   logic [31:0] pc;
   logic [9:0]  data_out;
   logic        out_strobe;

   logic [31:0] rom [256];
   logic [31:0] rf [64];      // reference registers
   logic [31:0] exp_q [$];
   logic        ref_c, ref_v;
   integer      seed;
   int          n;
   int          prog_id;

   always #4 clk = ~clk;

   silver_cpu #(.reset_pc(32'd0), .out_width(10)) dut0 (
      .clk, .rst_n, .inst_rdata, .data_in, .pc, .data_out, .out_strobe
   );

   always @(negedge clk) inst_rdata <= rom[pc[9:2]];   // combinational fetch

   function automatic logic [31:0] enc(input logic [5:0] op, input logic [3:0] fn,
                                       input logic iw, input logic [5:0] w,
                                       input logic ia, input logic [5:0] a,
                                       input logic ib, input logic [5:0] b);
      return {iw, w, 1'b0, ia, a, ib, b, fn, op};
   endfunction

   function automatic logic [31:0] enc_lc(input logic [5:0] w, input logic neg,
                                          input logic [22:0] mag);
      return {1'b1, w, 1'b1, neg, mag};
   endfunction

   function automatic logic [31:0] sx6(input logic [5:0] f);
      return {{26{f[5]}}, f};
   endfunction

   function automatic logic [31:0] alu(input logic [3:0] fn, input logic [31:0] x, y);
      logic [32:0]     s;
      longint          sv;
      longint unsigned pr;
      case (fn)
         4'd0: begin
            s = {1'b0, x} + {1'b0, y};
            sv = longint'($signed(x)) + longint'($signed(y));
            ref_c = s[32];
            ref_v = sv > 64'sd2147483647 || sv < -64'sd2147483648;
            return s[31:0];
         end
         4'd1: begin
            s = {1'b0, x} + {1'b0, y} + {32'd0, ref_c};
            ref_c = s[32];
            return s[31:0];
         end
         4'd2: begin
            sv = longint'($signed(x)) - longint'($signed(y));
            ref_v = sv > 64'sd2147483647 || sv < -64'sd2147483648;
            return x - y;
         end
         4'd3: return {31'd0, ref_c};
         4'd4: return {31'd0, ref_v};
         4'd5: return x + 1;
         4'd6: return x - 1;
         4'd7: return x * y;
         4'd8: begin
            pr = x;
            pr = pr * y;   // unsigned high half
            return pr[63:32];
         end
         4'd9:  return x & y;
         4'd10: return x | y;
         4'd11: return x ^ y;
         4'd12: return {31'd0, x == y};
         4'd13: return {31'd0, $signed(x) < $signed(y)};
         4'd14: return {31'd0, x < y};
         default: return y;
      endcase
   endfunction

   function automatic logic [31:0] shf(input logic [1:0] k, input logic [31:0] x, y);
      logic [31:0] t;
      int          i;
      case (k)
         2'd0: return (y > 31) ? 32'd0 : x << y[4:0];
         2'd1: return (y > 31) ? 32'd0 : x >> y[4:0];
         2'd2: return (y > 31) ? {32{x[31]}} : 32'($signed(x) >>> y[4:0]);
         default: begin
            t = x;
            for (i = 0; i < int'(y[4:0]); i++)
               t = {t[0], t[31:1]};
            return t;
         end
      endcase
   endfunction

   // instruction level model without delay slots
   function automatic void ref_model(input logic [1:0] din);
      logic [31:0] p, np, ins, x, y, z, r;
      logic [5:0]  op;
      int          steps;
      foreach (rf[i]) rf[i] = 32'd0;
      ref_c = 1'b0;
      ref_v = 1'b0;
      p = 32'd0;
      exp_q.delete();
      for (steps = 0; steps < 2000; steps++) begin
         ins = rom[p[9:2]];
         op = ins[5:0];
         np = p + 4;
         x = ins[23] ? sx6(ins[22:17]) : rf[ins[22:17]];
         y = ins[16] ? sx6(ins[15:10]) : rf[ins[15:10]];
         z = ins[31] ? sx6(ins[30:25]) : rf[ins[30:25]];
         if (ins[24]) begin
            if (ins[31])
               rf[ins[30:25]] = ins[23] ? 32'd0 - {9'd0, ins[22:0]} : {9'd0, ins[22:0]};
         end else if (op == 10 || op == 11 || (!ins[31] && op inside {0, 1, 6, 7, 9})) begin
            case (op)
               0, 6: begin
                  r = alu(ins[9:6], x, y);
                  rf[ins[30:25]] = r;
                  if (op == 6)
                     exp_q.push_back(r);
               end
               1: rf[ins[30:25]] = shf(ins[7:6], x, y);
               7: rf[ins[30:25]] = {30'd0, din};
               9: begin
                  r = alu(ins[9:6], p, x);
                  if (r == p)
                     return;   // jump to itself ends the program
                  rf[ins[30:25]] = p + 4;
                  np = r;
               end
               10: if (alu(ins[9:6], x, y) == 0) np = p + z;
               default: if (alu(ins[9:6], x, y) != 0) np = p + z;
            endcase
         end
         p = np;
      end
   endfunction

   task automatic clear_rom;
      for (int i = 0; i < 256; i++)
         rom[i] = {8'h00, i[17:0], 6'd15};   // invalid opcode with the address in the middle
      n = 0;
   endtask

   task automatic put(input logic [31:0] w);
      rom[n] = w;
      n++;
   endtask

   task automatic rr(input logic [5:0] op, input logic [3:0] fn, input logic [5:0] w, a, b);
      put(enc(op, fn, 1'b0, w, 1'b0, a, 1'b0, b));
   endtask

   task automatic ri(input logic [5:0] op, input logic [3:0] fn, input logic [5:0] w, a, b);
      put(enc(op, fn, 1'b0, w, 1'b0, a, 1'b1, b));
   endtask

   task automatic out_reg(input logic [5:0] r);
      rr(silver_isa_pkg::op_out, silver_isa_pkg::f_snd, 6'd63, 6'd0, r);
   endtask

   task automatic out_func(input logic [3:0] fn);
      rr(silver_isa_pkg::op_out, fn, 6'd63, 6'd0, 6'd0);
   endtask

   task automatic poison;
      ri(silver_isa_pkg::op_out, silver_isa_pkg::f_snd, 6'd63, 6'd0, 6'd31);
   endtask

   task automatic halt;
      put(enc(silver_isa_pkg::op_jump, silver_isa_pkg::f_add, 1'b0, 6'd62,
              1'b1, 6'd0, 1'b0, 6'd0));
   endtask

   task automatic fail_now;
      $display("Test failures found");
      $fatal(1, "simulation stopped");
   endtask

   // compares each output port write with the model
   always @(negedge clk) begin : compare_outputs
      logic [31:0] e;
      if (out_strobe) begin
         assert (exp_q.size() != 0) else begin
            $display("unexpected output %0h in program %0d", data_out, prog_id);
            fail_now();
         end
         e = exp_q.pop_front();
         assert (data_out == e[9:0]) else begin
            $display("ERR %0t program %0d expected %0h got %0h", $time, prog_id, e[9:0],
                     data_out);
            fail_now();
         end
      end
   end

   task automatic run_program(input logic [1:0] din);
      int cnt;
      ref_model(din);
      @(negedge clk);
      rst_n = 1'b0;
      data_in = din;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      assert (pc == 32'd0 && !out_strobe) else begin
         $display("ERR %0t pc %0h or out_strobe %0b wrong after reset", $time, pc, out_strobe);
         fail_now();
      end
      cnt = 0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
         cnt++;
         if (cnt > 3000) begin
            $display("program %0d still waits for %0d outputs that never arrived",
                     prog_id, exp_q.size());
            fail_now();
         end
      end
      repeat (20) @(negedge clk);   // no further output expected here
      prog_id++;
   endtask

   initial begin
      logic [31:0] t;
      int          last [3];
      int          ra, rb, rw, r;
      rst_n = 1'b0;
      inst_rdata = 32'd0;
      data_in = 2'd0;
      seed = 32'h94aa_94a1;
      prog_id = 0;
      clear_rom();

      // constants
      for (int i = 1; i < 7; i++) begin
         t = $random(seed);
         put(enc_lc(6'(i), i[0], t[22:0]));
         out_reg(6'(i));
      end
      halt();
      run_program(2'd0);

      // random alu sequences with short dependencies
      clear_rom();
      for (int i = 1; i < 8; i++) begin
         t = $random(seed);
         put(enc_lc(6'(i), t[23], t[22:0]));
      end
      last = '{1, 2, 3};
      for (int k = 0; k < 48; k++) begin
         t = $random(seed);
         rw = 1 + ($unsigned($random(seed)) % 7);
         r = $unsigned($random(seed)) % 4;
         ra = (r < 3) ? last[r] : 1 + ($unsigned($random(seed)) % 7);
         r = $unsigned($random(seed)) % 4;
         rb = (r < 3) ? last[r] : 1 + ($unsigned($random(seed)) % 7);
         put(enc(t[0] ? silver_isa_pkg::op_out : silver_isa_pkg::op_normal, 4'(k % 16),
                 1'b0, 6'(rw), t[1] & t[2], t[1] & t[2] ? t[13:8] : 6'(ra),
                 t[3] & t[4], t[3] & t[4] ? t[19:14] : 6'(rb)));
         last = '{rw, last[0], last[1]};
      end
      halt();
      run_program(2'd1);

      // carry and overflow on edge operands
      clear_rom();
      put(enc_lc(6'd1, 1'b1, 23'd1));
      put(enc_lc(6'd2, 1'b0, 23'd1));
      ri(silver_isa_pkg::op_shift, 4'(silver_isa_pkg::sh_srl), 6'd4, 6'd1, 6'd1);
      rr(silver_isa_pkg::op_normal, silver_isa_pkg::f_add, 6'd3, 6'd1, 6'd2);
      out_func(silver_isa_pkg::f_carry);
      out_func(silver_isa_pkg::f_overflow);
      rr(silver_isa_pkg::op_normal, silver_isa_pkg::f_add, 6'd7, 6'd4, 6'd2);
      out_func(silver_isa_pkg::f_carry);
      out_func(silver_isa_pkg::f_overflow);
      rr(silver_isa_pkg::op_normal, silver_isa_pkg::f_add_carry, 6'd8, 6'd1, 6'd1);
      out_func(silver_isa_pkg::f_carry);
      out_reg(6'd8);
      rr(silver_isa_pkg::op_normal, silver_isa_pkg::f_add_carry, 6'd9, 6'd2, 6'd2);
      out_reg(6'd9);
      out_func(silver_isa_pkg::f_carry);
      rr(silver_isa_pkg::op_normal, silver_isa_pkg::f_sub, 6'd10, 6'd7, 6'd2);
      out_func(silver_isa_pkg::f_overflow);
      rr(silver_isa_pkg::op_normal, silver_isa_pkg::f_sub, 6'd11, 6'd2, 6'd2);
      out_func(silver_isa_pkg::f_overflow);
      rr(silver_isa_pkg::op_normal, silver_isa_pkg::f_sub, 6'd12, 6'd4, 6'd1);
      out_func(silver_isa_pkg::f_overflow);
      halt();
      run_program(2'd2);

      // shifts of all kinds with the high result bits shown too
      clear_rom();
      for (int i = 1; i < 4; i++) begin
         t = $random(seed);
         put(enc_lc(6'(i), t[23], t[22:0]));
      end
      put(enc_lc(6'd4, 1'b0, 23'd40));
      ri(silver_isa_pkg::op_shift, 4'(silver_isa_pkg::sh_ror), 6'd10, 6'd1, 6'd0);
      out_reg(6'd10);
      for (int k = 0; k < 16; k++) begin
         t = $random(seed);
         if (k % 2 == 0)
            ri(silver_isa_pkg::op_shift, 4'((k / 2) % 4), 6'd10, 6'(1 + k % 3), t[5:0]);
         else
            rr(silver_isa_pkg::op_shift, 4'((k / 2) % 4), 6'd10, 6'(1 + k % 3), 6'd4);
         out_reg(6'd10);
         ri(silver_isa_pkg::op_shift, 4'(silver_isa_pkg::sh_srl), 6'd11, 6'd10, 6'd22);
         out_reg(6'd11);
      end
      halt();
      run_program(2'd3);

      // jumps, links and squashed slots
      clear_rom();
      put(enc_lc(6'd1, 1'b0, 23'd5));
      put(enc_lc(6'd2, 1'b0, 23'd5));
      put(enc(silver_isa_pkg::op_jump_zero, silver_isa_pkg::f_sub, 1'b1, 6'd12,
              1'b0, 6'd1, 1'b0, 6'd2));
      poison();
      poison();
      put(enc(silver_isa_pkg::op_jump_not_zero, silver_isa_pkg::f_sub, 1'b1, 6'd12,
              1'b0, 6'd1, 1'b0, 6'd2));
      out_reg(6'd1);
      put(enc(silver_isa_pkg::op_jump, silver_isa_pkg::f_add, 1'b0, 6'd3,
              1'b1, 6'd12, 1'b0, 6'd0));
      poison();
      poison();
      out_reg(6'd3);
      put(enc_lc(6'd4, 1'b0, 23'd12));
      put(enc(silver_isa_pkg::op_jump_not_zero, silver_isa_pkg::f_xor, 1'b0, 6'd4,
              1'b0, 6'd1, 1'b1, 6'd1));   // offset from a register just written
      poison();
      poison();
      out_reg(6'd4);
      put(enc(silver_isa_pkg::op_jump_zero, silver_isa_pkg::f_sub, 1'b1, 6'd8,
              1'b0, 6'd1, 1'b0, 6'd4));
      out_reg(6'd1);
      halt();
      run_program(2'd0);

      // input port with one reset per value
      for (int v = 0; v < 4; v++) begin
         clear_rom();
         rr(silver_isa_pkg::op_in, 4'd0, 6'd1, 6'd0, 6'd0);
         out_reg(6'd1);
         halt();
         run_program(2'(v));
      end

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
rtl/silver_isa_pkg.sv
rtl/silver_pipe_pkg.sv
rtl/silver_fetch.sv
rtl/silver_regfile.sv
rtl/silver_decode.sv
rtl/silver_forward.sv
rtl/silver_execute.sv
rtl/silver_retire.sv
rtl/silver_cpu.sv
testbench/silver_tb.sv
